// File: source/lsuPkg.sv
// Package with the funct3 union, access size and MemRW codes, and the byte swap function
`default_nettype none

package lsuPkg;

  // Widest word the swap function handles
  localparam int MAX_XLEN = 64;

  // Access size codes from Funct3[1:0]
  localparam logic [1:0] SIZE_BYTE   = 2'd0;
  localparam logic [1:0] SIZE_HALF   = 2'd1;
  localparam logic [1:0] SIZE_WORD   = 2'd2;
  localparam logic [1:0] SIZE_DOUBLE = 2'd3;

  // MemRW strobes with read in bit 1 and write in bit 0
  localparam logic [1:0] MEM_IDLE  = 2'b00;
  localparam logic [1:0] MEM_WRITE = 2'b01;
  localparam logic [1:0] MEM_READ  = 2'b10;

  // Funct3 of a load or store, either as the raw code or split in two fields
  typedef union packed {
    logic [2:0] raw;                  // Funct3 straight from the decoder
    struct packed {
      logic       isUnsigned;         // LBU, LHU and LWU
      logic [1:0] size;               // Log2 of the access bytes
    } fields;
  } memOpT;

  // Reverse the order of the low nBytes bytes of a word
  // Bytes above nBytes come back as zero
  function automatic logic [MAX_XLEN-1:0] endianSwap(
    input logic [MAX_XLEN-1:0] word,
    input int unsigned         nBytes
  );
    logic [MAX_XLEN-1:0] swapped;
    swapped = '0;
    for (int i = 0; i < MAX_XLEN/8; i++) begin
      if (i < nBytes) begin
        swapped[8*i +: 8] = word[8*(nBytes-1-i) +: 8];  // Lane i takes lane n-1-i
      end
    end
    return swapped;
  endfunction

endpackage

`default_nettype wire

// File: source/lsuRequest.sv
// E-to-M address register, misalignment faults, byte mask and store data replication and swap
`timescale 1ns/1ns
`default_nettype none

module lsuRequest import lsuPkg::*; #(
  parameter int XLEN = 32                        // Data and address width
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              StallM,                   // Hold the M address
  input  logic [XLEN-1:0]   IEUAdrE,                  // Address computed in E
  input  logic [1:0]        MemRWM,                   // Read and write strobes of M
  input  memOpT             Funct3M,                  // Size and signedness
  input  logic [XLEN-1:0]   WriteDataM,               // Store data from the IEU
  input  logic              BigEndianM,               // Memory is big-endian
  output logic [XLEN-1:0]   IEUAdrM,                  // Registered M address
  output logic [XLEN/8-1:0] ByteMaskM,                // Bytes touched by the access
  output logic [XLEN-1:0]   StoreDataM,               // Lane-aligned store data
  output logic              LoadMisalignedFaultM,
  output logic              StoreAmoMisalignedFaultM,
  output logic              MisalignedM               // Any access off its natural boundary
);

  localparam int BYTES = XLEN/8;                      // Bytes per word
  localparam int OFFB  = $clog2(BYTES);               // Byte offset bits

  logic [2:0]          lowAdrM;                       // Low three address bits
  logic [2:0]          alignMaskM;                    // Offset bits that must be zero
  logic [BYTES-1:0]    sizeMaskM;                     // Mask before the shift to the offset
  logic [XLEN-1:0]     replDataM;                     // Store data copied over every lane
  logic [MAX_XLEN-1:0] swappedM;                      // Replicated data in big-endian order

  ////////////////////////////////////////////////////////////////////////////
  // Address register from E to M
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      IEUAdrM <= '0;
    end else if (!StallM) begin
      IEUAdrM <= IEUAdrE;                             // Advance with the pipeline
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Alignment check
  ////////////////////////////////////////////////////////////////////////////

  assign lowAdrM = IEUAdrM[2:0];

  always_comb begin
    case (Funct3M.fields.size)
      SIZE_BYTE: alignMaskM = 3'b000;                 // Bytes are always aligned
      SIZE_HALF: alignMaskM = 3'b001;
      SIZE_WORD: alignMaskM = 3'b011;
      default:   alignMaskM = 3'b111;
    endcase
  end

  assign MisalignedM = (|(lowAdrM & alignMaskM)) & (|MemRWM);

  // A read-modify-write counts as a store fault
  assign LoadMisalignedFaultM     = MisalignedM & (MemRWM == MEM_READ);
  assign StoreAmoMisalignedFaultM = MisalignedM & MemRWM[0];

  ////////////////////////////////////////////////////////////////////////////
  // Byte mask
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < BYTES; b++) begin
      sizeMaskM[b] = (b < (1 << Funct3M.fields.size));  // Low 2^size bytes set
    end
  end

  assign ByteMaskM = sizeMaskM << IEUAdrM[OFFB-1:0];  // Move to the byte offset

  ////////////////////////////////////////////////////////////////////////////
  // Store data replication and endian swap
  ////////////////////////////////////////////////////////////////////////////

  // Every lane carries the data so the mask alone picks the target bytes
  always_comb begin
    case (Funct3M.fields.size)
      SIZE_BYTE: replDataM = {BYTES{WriteDataM[7:0]}};
      SIZE_HALF: replDataM = {(BYTES/2){WriteDataM[15:0]}};
      SIZE_WORD: replDataM = {(XLEN/32){WriteDataM[31:0]}};
      default:   replDataM = WriteDataM;              // Full word
    endcase
  end

  assign swappedM   = endianSwap(MAX_XLEN'(replDataM), BYTES);
  assign StoreDataM = BigEndianM ? swappedM[XLEN-1:0] : replDataM;

endmodule

`default_nettype wire

// File: source/dtimMem.sv
// Synchronous byte-masked data memory with E-stage read and M-stage write
`timescale 1ns/1ns
`default_nettype none

module dtimMem #(
  parameter int XLEN       = 32,                      // Word width
  parameter int DTIM_WORDS = 64                       // Depth in words
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              StallM,                   // Keep the read word of a stalled load
  input  logic [1:0]        MemRWE,                   // Read strobe in bit 1
  input  logic [XLEN-1:0]   ReadAdrE,                 // Load address in E
  input  logic [XLEN-1:0]   WriteAdrM,                // Store address in M
  input  logic              WriteEnM,                 // Final write enable
  input  logic [XLEN/8-1:0] ByteMaskM,                // Per-byte write enables
  input  logic [XLEN-1:0]   StoreDataM,
  output logic [XLEN-1:0]   ReadDataWordM             // Word read in E, valid in M
);

  localparam int BYTES = XLEN/8;
  localparam int OFFB  = $clog2(BYTES);
  localparam int AW    = $clog2(DTIM_WORDS);          // Word index bits

  logic [XLEN-1:0] mem [DTIM_WORDS];                  // Storage array
  logic [AW-1:0]   readIdxE;
  logic [AW-1:0]   writeIdxM;

  // Word index drops the byte offset
  assign readIdxE  = ReadAdrE[OFFB +: AW];
  assign writeIdxM = WriteAdrM[OFFB +: AW];

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ReadDataWordM <= '0;
    end else if (!StallM && MemRWE[1]) begin
      ReadDataWordM <= mem[readIdxE];                 // Load moves into M
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write port with byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int b = 0; b < BYTES; b++) begin
      if (WriteEnM && ByteMaskM[b]) begin
        mem[writeIdxM][8*b +: 8] <= StoreDataM[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lrscReservation.sv
// LR/SC reservation register, store-conditional outcome and the final write enable
`timescale 1ns/1ns
`default_nettype none

module lrscReservation import lsuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            StallW,                     // Update held while W stalls
  input  logic [1:0]      MemRWM,
  input  logic            LrScM,                      // Access is an LR or SC
  input  logic [XLEN-1:0] IEUAdrM,
  input  logic            MisalignedM,                // Misaligned accesses change nothing
  output logic            WriteEnM,                   // Write reaches the DTIM
  output logic            SquashSCM                   // SC failed
);

  localparam int OFFB = $clog2(XLEN/8);

  logic                 resValid;                     // Reservation is held
  logic [XLEN-OFFB-1:0] resAdr;                       // Reserved word address
  logic [XLEN-OFFB-1:0] wordAdrM;
  logic                 lrM;
  logic                 scM;
  logic                 resHitM;

  assign wordAdrM = IEUAdrM[XLEN-1:OFFB];
  assign lrM      = LrScM & (MemRWM == MEM_READ);
  assign scM      = LrScM & (MemRWM == MEM_WRITE);
  assign resHitM  = resValid & (resAdr == wordAdrM);  // SC would succeed

  ////////////////////////////////////////////////////////////////////////////
  // Write enable and SC result
  ////////////////////////////////////////////////////////////////////////////

  // Plain stores pass and an SC needs a hit
  assign WriteEnM  = MemRWM[0] & ~MisalignedM & ~StallW & (~scM | resHitM);
  assign SquashSCM = scM & ~resHitM;

  ////////////////////////////////////////////////////////////////////////////
  // Reservation state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (!StallW && !MisalignedM) begin
      if (lrM) begin
        resValid <= 1'b1;                             // LR reserves its word
      end else if (scM) begin
        resValid <= 1'b0;                             // Any SC drops it
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!StallW && !MisalignedM && lrM) begin
      resAdr <= wordAdrM;
    end
  end

endmodule

`default_nettype wire

// File: source/loadFormat.sv
// Load byte swap, subword select with extension, and the M-to-W registers
`timescale 1ns/1ns
`default_nettype none

module loadFormat import lsuPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            StallW,                     // Hold the W registers
  input  logic [XLEN-1:0] ReadDataWordM,              // Raw memory word
  input  logic [XLEN-1:0] IEUAdrM,                    // Only the byte offset matters here
  input  memOpT           Funct3M,
  input  logic            BigEndianM,
  input  logic            SquashSCM,
  output logic [XLEN-1:0] ReadDataW,                  // Extended load value
  output logic            SquashSCW
);

  localparam int         BYTES    = XLEN/8;
  localparam int         OFFB     = $clog2(BYTES);
  localparam logic [1:0] MAX_SIZE = 2'(OFFB);         // Widest size one word holds

  logic [MAX_XLEN-1:0] swappedM;
  logic [XLEN-1:0]     wordLeM;                       // Word in little-endian lane order
  logic [1:0]          effSizeM;                      // Size clipped to the word
  logic [OFFB:0]       sizeBytesM;
  logic [OFFB-1:0]     offsetM;
  logic [OFFB-1:0]     selOffsetM;                    // Lane where the subword starts
  logic [XLEN-1:0]     shiftedM;
  logic [XLEN-1:0]     readDataM;

  ////////////////////////////////////////////////////////////////////////////
  // Endian swap and subword select
  ////////////////////////////////////////////////////////////////////////////

  assign swappedM = endianSwap(MAX_XLEN'(ReadDataWordM), BYTES);
  assign wordLeM  = BigEndianM ? swappedM[XLEN-1:0] : ReadDataWordM;

  assign effSizeM   = (Funct3M.fields.size > MAX_SIZE) ? MAX_SIZE : Funct3M.fields.size;
  assign sizeBytesM = (OFFB+1)'(1) << effSizeM;
  assign offsetM    = IEUAdrM[OFFB-1:0];

  // Swapping mirrors the lanes so the offset is mirrored too
  assign selOffsetM = BigEndianM ? OFFB'(BYTES - sizeBytesM - offsetM) : offsetM;
  assign shiftedM   = wordLeM >> {selOffsetM, 3'b000};

  // Sign or zero extension
  always_comb begin
    case (Funct3M.fields.size)
      SIZE_BYTE: readDataM = Funct3M.fields.isUnsigned ? XLEN'(shiftedM[7:0])
                                                       : XLEN'($signed(shiftedM[7:0]));
      SIZE_HALF: readDataM = Funct3M.fields.isUnsigned ? XLEN'(shiftedM[15:0])
                                                       : XLEN'($signed(shiftedM[15:0]));
      SIZE_WORD: readDataM = Funct3M.fields.isUnsigned ? XLEN'(shiftedM[31:0])
                                                       : XLEN'($signed(shiftedM[31:0]));
      default:   readDataM = shiftedM;                // Full word needs no extension
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // M to W registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ReadDataW <= '0;
      SquashSCW <= 1'b0;
    end else if (!StallW) begin
      ReadDataW <= readDataM;
      SquashSCW <= SquashSCM;                         // Keeps rd unwritten on a failed SC
    end
  end

endmodule

`default_nettype wire

// File: source/lsu.sv
// Load/store unit top level connecting request, DTIM, reservation and load format stages
`timescale 1ns/1ns
`default_nettype none

module lsu import lsuPkg::*; #(
  parameter int XLEN       = 32,                      // Data and address width
  parameter int DTIM_WORDS = 64                       // DTIM depth in words
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            StallM,
  input  logic            StallW,
  input  logic [1:0]      MemRWE,                     // E-stage read and write strobes
  input  logic [XLEN-1:0] IEUAdrE,
  input  logic [1:0]      MemRWM,
  input  memOpT           Funct3M,                    // Size and signedness in M
  input  logic            LrScM,
  input  logic [XLEN-1:0] WriteDataM,
  input  logic            BigEndianM,
  output logic [XLEN-1:0] IEUAdrM,
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM,
  output logic [XLEN-1:0] ReadDataW,
  output logic            SquashSCW
);

  logic [XLEN/8-1:0] ByteMaskM;
  logic [XLEN-1:0]   StoreDataM;                      // Replicated and swapped store data
  logic              MisalignedM;
  logic              WriteEnM;                        // Store or successful SC
  logic              SquashSCM;
  logic [XLEN-1:0]   ReadDataWordM;                   // Raw DTIM word in M

  ////////////////////////////////////////////////////////////////////////////
  // Request side and DTIM
  ////////////////////////////////////////////////////////////////////////////

  lsuRequest #(.XLEN(XLEN)) lsuRequest_i (
    .clk, .rstN, .StallM, .IEUAdrE, .MemRWM, .Funct3M, .WriteDataM, .BigEndianM,
    .IEUAdrM, .ByteMaskM, .StoreDataM, .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
    .MisalignedM
  );

  dtimMem #(.XLEN(XLEN), .DTIM_WORDS(DTIM_WORDS)) dtimMem_i (
    .clk, .rstN, .StallM, .MemRWE,
    .ReadAdrE(IEUAdrE),                               // Read starts in E
    .WriteAdrM(IEUAdrM),
    .WriteEnM, .ByteMaskM, .StoreDataM, .ReadDataWordM
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reservation and load return
  ////////////////////////////////////////////////////////////////////////////

  lrscReservation #(.XLEN(XLEN)) lrscReservation_i (
    .clk, .rstN, .StallW, .MemRWM, .LrScM, .IEUAdrM, .MisalignedM, .WriteEnM, .SquashSCM
  );

  loadFormat #(.XLEN(XLEN)) loadFormat_i (
    .clk, .rstN, .StallW, .ReadDataWordM, .IEUAdrM, .Funct3M, .BigEndianM, .SquashSCM,
    .ReadDataW, .SquashSCW
  );

endmodule

`default_nettype wire

// File: sim/lsu_chk.sv
// Concurrent assertions on reset state, fault exclusivity and write gating, bound into lsu
`timescale 1ns/1ns
`default_nettype none

module lsuChk (
  input logic clk,
  input logic rstN,
  input logic SquashSCW,
  input logic LoadMisalignedFaultM,
  input logic StoreAmoMisalignedFaultM,
  input logic WriteEnM,                               // Internal write enable of lsu
  input logic MisalignedM
);

  // W squash flag leaves reset cleared
  resetSquash: assert property (@(posedge clk) !rstN |=> !SquashSCW)
    else $error("SquashSCW high in the cycle after reset");

  oneFault: assert property (@(posedge clk) disable iff (!rstN)
    !(LoadMisalignedFaultM && StoreAmoMisalignedFaultM))
    else $error("Load and store misaligned faults high together");

  // A misaligned access never reaches the DTIM
  noMisalignedWrite: assert property (@(posedge clk) disable iff (!rstN)
    !(WriteEnM && MisalignedM))
    else $error("WriteEnM high on a misaligned access");

endmodule

bind lsu lsuChk lsuChk_i (
  .clk, .rstN, .SquashSCW, .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
  .WriteEnM, .MisalignedM
);

`default_nettype wire

// File: sim/lsuTb.sv
// Directed testbench for the load/store unit with a byte-array reference model and a watchdog
`timescale 1ns/1ns
`default_nettype none

module lsuTb import lsuPkg::*; ();

  localparam int XLEN        = 32;
  localparam int DTIM_WORDS  = 64;
  localparam int BYTES       = XLEN/8;
  localparam int MEM_BYTES   = DTIM_WORDS*BYTES;
  localparam int CLK_PERIOD  = 8;                     // ns
  localparam int SEED        = 21;
  localparam int TEST_COUNT  = 200;                   // Upper bound on accesses over all tests
  localparam int WATCHDOG_NS = TEST_COUNT*20*CLK_PERIOD;

  logic            clk;
  logic            rstN;
  logic            StallM;
  logic            StallW;
  logic [1:0]      MemRWE;
  logic [XLEN-1:0] IEUAdrE;
  logic [1:0]      MemRWM;
  memOpT           Funct3M;
  logic            LrScM;
  logic [XLEN-1:0] WriteDataM;
  logic            BigEndianM;
  logic [XLEN-1:0] IEUAdrM;
  logic            LoadMisalignedFaultM;
  logic            StoreAmoMisalignedFaultM;
  logic [XLEN-1:0] ReadDataW;
  logic            SquashSCW;

  logic [7:0]      refMem [MEM_BYTES];                // Expected DTIM contents by byte
  logic            refResValid;                       // Expected reservation state
  logic [XLEN-1:0] refResAdr;
  logic [XLEN-1:0] lastRead;                          // Results of the latest access
  logic            lastSquash;
  logic            lastLdFault;
  logic            lastStFault;
  int              wordErrors;
  int              flagErrors;

  lsu #(.XLEN(XLEN), .DTIM_WORDS(DTIM_WORDS)) lsu_i (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string what, input logic [XLEN-1:0] expected,
                           input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      wordErrors++;
      $display("Error at %0t ns: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      flagErrors++;
      $display("Error at %0t ns: %s expected %b got %b", $time, what, expected, actual);
    end
  endtask

  // Natural alignment for 2^size bytes
  function automatic logic offBoundary(input logic [XLEN-1:0] adr, input logic [1:0] size);
    return (adr % (1 << size)) != 0;
  endfunction

  function automatic memOpT buildOp(input logic isUnsigned, input logic [1:0] size);
    memOpT op;
    op.fields.isUnsigned = isUnsigned;
    op.fields.size       = size;
    return op;
  endfunction

  function automatic void modelStore(input logic [XLEN-1:0] adr, input logic [1:0] size,
                                     input logic [XLEN-1:0] data, input logic be);
    int n;
    n = 1 << size;
    for (int i = 0; i < n; i++) begin
      refMem[adr + i] = be ? data[8*(n-1-i) +: 8] : data[8*i +: 8];  // BE puts MSB first
    end
  endfunction

  function automatic logic [XLEN-1:0] modelLoad(input logic [XLEN-1:0] adr, input memOpT op,
                                                input logic be);
    logic [XLEN-1:0] v;
    int              n;
    n = 1 << op.fields.size;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = be ? refMem[adr + n-1-i] : refMem[adr + i];
    end
    if (!op.fields.isUnsigned && v[8*n-1]) begin
      for (int i = n; i < BYTES; i++) begin
        v[8*i +: 8] = 8'hFF;                          // Sign fill
      end
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Access tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic waitIdle();
    @(posedge clk);
  endtask

  // One access through E, M and W with nothing overlapping
  task automatic runAccess(input logic [1:0] rw, input logic [XLEN-1:0] adr, input memOpT op,
                           input logic lrsc, input logic [XLEN-1:0] data, input logic be);
    @(posedge clk);
    MemRWE     <= rw;
    IEUAdrE    <= adr;
    @(posedge clk);
    MemRWE     <= MEM_IDLE;
    IEUAdrE    <= '0;
    MemRWM     <= rw;                                 // Same access now in M
    Funct3M    <= op;
    LrScM      <= lrsc;
    WriteDataM <= data;
    BigEndianM <= be;
    @(negedge clk);
    checkWord("IEUAdrM in M", adr, IEUAdrM);
    lastLdFault = LoadMisalignedFaultM;               // Faults are combinational in M
    lastStFault = StoreAmoMisalignedFaultM;
    @(posedge clk);
    MemRWM     <= MEM_IDLE;
    LrScM      <= 1'b0;
    @(negedge clk);
    lastRead   = ReadDataW;                           // Two edges after E
    lastSquash = SquashSCW;
  endtask

  task automatic storeValue(input logic [XLEN-1:0] adr, input logic [1:0] size,
                            input logic [XLEN-1:0] data, input logic be);
    runAccess(MEM_WRITE, adr, buildOp(1'b0, size), 1'b0, data, be);
    checkFlag("store misaligned fault", offBoundary(adr, size), lastStFault);
    checkFlag("load fault on a store", 1'b0, lastLdFault);
    if (!offBoundary(adr, size)) begin
      modelStore(adr, size, data, be);
    end
  endtask

  task automatic loadCheck(input logic [XLEN-1:0] adr, input logic isUnsigned,
                           input logic [1:0] size, input logic be);
    memOpT op;
    op = buildOp(isUnsigned, size);
    runAccess(MEM_READ, adr, op, 1'b0, '0, be);
    checkFlag("load misaligned fault", offBoundary(adr, size), lastLdFault);
    checkFlag("store fault on a load", 1'b0, lastStFault);
    checkFlag("SquashSCW on a load", 1'b0, lastSquash);
    if (!offBoundary(adr, size)) begin
      checkWord($sformatf("load f3=%0d adr=%h be=%0b", op.raw, adr, be),
                modelLoad(adr, op, be), lastRead);
    end
  endtask

  // Every size, offset and signedness within one word
  task automatic loadAllWays(input logic [XLEN-1:0] base, input logic be);
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < BYTES; off += (1 << s)) begin
        loadCheck(base + off, 1'b0, 2'(s), be);
        loadCheck(base + off, 1'b1, 2'(s), be);
      end
    end
  endtask

  task automatic subwordRound(input logic be, output logic [XLEN-1:0] base);
    base = XLEN'($urandom_range(DTIM_WORDS-1) * BYTES);
    storeValue(base, SIZE_WORD, $urandom, be);         // Known background word
    storeValue(base + $urandom_range(3), SIZE_BYTE, $urandom, be);
    storeValue(base + 2*$urandom_range(1), SIZE_HALF, $urandom, be);
    waitIdle();
    loadAllWays(base, be);
  endtask

  task automatic lrAccess(input logic [XLEN-1:0] adr);
    runAccess(MEM_READ, adr, buildOp(1'b0, SIZE_WORD), 1'b1, '0, 1'b0);
    checkWord("LR data", modelLoad(adr, buildOp(1'b0, SIZE_WORD), 1'b0), lastRead);
    refResValid = 1'b1;
    refResAdr   = adr;
  endtask

  task automatic scAccess(input logic [XLEN-1:0] adr, input logic [XLEN-1:0] data);
    logic hit;
    hit = refResValid && (refResAdr / BYTES == adr / BYTES);
    runAccess(MEM_WRITE, adr, buildOp(1'b0, SIZE_WORD), 1'b1, data, 1'b0);
    checkFlag("SquashSCW after SC", !hit, lastSquash);
    if (hit) begin
      modelStore(adr, SIZE_WORD, data, 1'b0);
    end
    refResValid = 1'b0;                               // Any SC drops it
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testWordAccess();
    logic [XLEN-1:0] adrs [8];
    for (int i = 0; i < 8; i++) begin
      adrs[i] = XLEN'((i*8 + $urandom_range(7)) * BYTES);  // One word per eighth of the DTIM
      storeValue(adrs[i], SIZE_WORD, $urandom, 1'b0);
    end
    waitIdle();
    for (int i = 0; i < 8; i++) begin
      loadCheck(adrs[i], 1'b0, SIZE_WORD, 1'b0);
    end
  endtask

  task automatic testSubword();
    logic [XLEN-1:0] base;
    for (int r = 0; r < 3; r++) begin
      subwordRound(1'b0, base);
    end
  endtask

  task automatic testBigEndian();
    logic [XLEN-1:0] base;
    for (int r = 0; r < 3; r++) begin
      subwordRound(1'b1, base);
      loadAllWays(base, 1'b0);                        // Same bytes read little-endian
    end
  endtask

  task automatic testMisaligned();
    logic [XLEN-1:0] base;
    base = XLEN'($urandom_range(DTIM_WORDS-1) * BYTES);
    storeValue(base, SIZE_WORD, $urandom, 1'b0);
    waitIdle();
    for (int off = 1; off < BYTES; off++) begin
      loadCheck(base + off, 1'b0, SIZE_WORD, 1'b0);
      storeValue(base + off, SIZE_WORD, $urandom, 1'b0);  // Must write nothing
      if (off % 2 == 1) begin
        loadCheck(base + off, 1'b1, SIZE_HALF, 1'b0);
        storeValue(base + off, SIZE_HALF, $urandom, 1'b0);
      end
    end
    waitIdle();
    loadCheck(base, 1'b0, SIZE_WORD, 1'b0);           // Word as before
  endtask

  task automatic testLrSc();
    logic [XLEN-1:0] adrA;
    logic [XLEN-1:0] adrB;
    adrA = XLEN'($urandom_range(DTIM_WORDS-1) * BYTES);
    adrB = XLEN'((adrA + BYTES * $urandom_range(DTIM_WORDS-1, 1)) % MEM_BYTES);
    storeValue(adrA, SIZE_WORD, $urandom, 1'b0);
    storeValue(adrB, SIZE_WORD, $urandom, 1'b0);
    waitIdle();
    lrAccess(adrA);
    scAccess(adrA, $urandom);                         // Hit so the word is written
    waitIdle();
    loadCheck(adrA, 1'b0, SIZE_WORD, 1'b0);
    scAccess(adrA, $urandom);                         // Reservation already gone
    waitIdle();
    loadCheck(adrA, 1'b0, SIZE_WORD, 1'b0);
    lrAccess(adrA);
    scAccess(adrB, $urandom);                         // Other word
    waitIdle();
    loadCheck(adrB, 1'b0, SIZE_WORD, 1'b0);
  endtask

  task automatic testStall();
    logic [XLEN-1:0] adrA;
    logic [XLEN-1:0] adrB;
    logic [XLEN-1:0] valA;
    adrA = XLEN'($urandom_range(DTIM_WORDS-1) * BYTES);
    adrB = adrA ^ XLEN'(BYTES);                       // Neighbour word
    valA = $urandom;
    storeValue(adrA, SIZE_WORD, valA, 1'b0);
    storeValue(adrB, SIZE_WORD, ~valA, 1'b0);
    waitIdle();
    loadCheck(adrA, 1'b0, SIZE_WORD, 1'b0);           // A now sits in W
    @(posedge clk);
    MemRWE  <= MEM_READ;                              // B enters E
    IEUAdrE <= adrB;
    StallW  <= 1'b1;
    @(posedge clk);
    MemRWE  <= MEM_READ;                              // Another load of A waits in E
    IEUAdrE <= adrA;
    StallM  <= 1'b1;                                  // Keep B in M
    MemRWM  <= MEM_READ;
    Funct3M <= buildOp(1'b0, SIZE_WORD);
    BigEndianM <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      checkWord("ReadDataW under StallW", modelLoad(adrA, Funct3M, 1'b0), ReadDataW);
      checkWord("IEUAdrM under StallM", adrB, IEUAdrM);
    end
    @(posedge clk);
    StallM  <= 1'b0;
    StallW  <= 1'b0;
    @(posedge clk);                                   // B reaches W
    MemRWE  <= MEM_IDLE;
    IEUAdrE <= '0;
    MemRWM  <= MEM_IDLE;
    @(negedge clk);
    checkWord("ReadDataW after StallW falls", modelLoad(adrB, Funct3M, 1'b0), ReadDataW);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    wordErrors  = 0;
    flagErrors  = 0;
    refResValid = 1'b0;
    rstN        = 1'b0;
    StallM      = 1'b0;
    StallW      = 1'b0;
    MemRWE      = MEM_IDLE;
    IEUAdrE     = '0;
    MemRWM      = MEM_IDLE;
    Funct3M     = '0;
    LrScM       = 1'b0;
    WriteDataM  = '0;
    BigEndianM  = 1'b0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkWord("IEUAdrM after reset", '0, IEUAdrM);
    checkWord("ReadDataW after reset", '0, ReadDataW);
    checkFlag("SquashSCW after reset", 1'b0, SquashSCW);
    testWordAccess();
    testSubword();
    testBigEndian();
    testMisaligned();
    testLrSc();
    testStall();
    $display("Word errors: %0d, flag errors: %0d", wordErrors, flagErrors);
    if (wordErrors + flagErrors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/lsuPkg.sv
source/lsuRequest.sv
source/dtimMem.sv
source/lrscReservation.sv
source/loadFormat.sv
source/lsu.sv
sim/lsu_chk.sv
sim/lsuTb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - source/lsuPkg.sv
  - source/lsuRequest.sv
  - source/dtimMem.sv
  - source/lrscReservation.sv
  - source/loadFormat.sv
  - source/lsu.sv
  - target: simulation
    files:
      - sim/lsu_chk.sv
      - sim/lsuTb.sv
